// ==== logic/pitaya_params.svh ====
/* widths, bus region numbers and register offsets of the analog path
   included by the package and by the register blocks */
`ifndef PITAYA_PARAMS_SVH
`define PITAYA_PARAMS_SVH

`define ADC_W          14             // sample and DAC code width
`define SUM_W          15             // mixer sum before saturation
`define ADC_RAW_W      16             // ADC pins, low 2 bits unused
`define BUS_W          32             // system bus address and data

`define REG_NUM        8              // bus regions
`define RGN_LSB        20             // region number sits at addr[22:20]
`define RGN_HK         3'd0           // housekeeping
`define RGN_DAC        3'd2           // DAC configuration

`define HK_ID_OFS      20'h00000
`define HK_LOOP_OFS    20'h00004
`define CFG_LVL_A_OFS  20'h00000
`define CFG_LVL_B_OFS  20'h00004
`define CFG_BIAS_A_OFS 20'h00008
`define CFG_BIAS_B_OFS 20'h0000C
`define PITAYA_ID      32'h5250_0A01  // read-only board ID
`endif

// ==== logic/pitaya_pkg.sv ====
/* data and bus types shared by the analog path modules
   import with pitaya_pkg::* in the module header */
`default_nettype none

`include "pitaya_params.svh"

package pitaya_pkg;

  //////////////////////////////////////////////////
  // stream types

  typedef logic signed [`ADC_W-1:0]     sample_t;    // two's complement
  typedef logic        [`ADC_W-1:0]     dac_code_t;  // unsigned, negative slope
  typedef logic        [`ADC_RAW_W-1:0] adc_raw_t;   // ADC pin word
  typedef logic signed [`SUM_W-1:0]     sum_t;       // one guard bit

  //////////////////////////////////////////////////
  // system bus types

  typedef logic [`BUS_W-1:0]   bus_word_t;
  typedef logic [2:0]          region_t;      // addr[22:20]
  typedef logic [`REG_NUM-1:0] region_vec_t;  // one strobe per region

endpackage

`default_nettype wire

// ==== logic/sys_bus_decoder.sv ====
/* splits the system bus into 8 regions by address bits 22 to 20
   fans out strobes and returns the selected slave's answer */
`timescale 1ns/1ps
`default_nettype none

`include "pitaya_params.svh"

module sys_bus_decoder
  import pitaya_pkg::*;
(
  input  bus_word_t   sys_addr_i,   // held until ack
  input  logic        sys_wen_i,    // single-cycle write strobe
  input  logic        sys_ren_i,    // single-cycle read strobe
  output bus_word_t   sys_rdata_o,
  output logic        sys_ack_o,
  output logic        sys_err_o,
  output region_vec_t rgn_wen_o,    // one-hot per region
  output region_vec_t rgn_ren_o,
  input  bus_word_t   hk_rdata_i,   // region 0
  input  logic        hk_ack_i,
  input  logic        hk_err_i,
  input  bus_word_t   cfg_rdata_i,  // region 2
  input  logic        cfg_ack_i,
  input  logic        cfg_err_i
);

  region_t     rgn;
  region_vec_t rgn_cs;

  assign rgn    = sys_addr_i[`RGN_LSB +: $bits(region_t)];
  assign rgn_cs = region_vec_t'(1) << rgn;  // chip select

  assign rgn_wen_o = rgn_cs & {`REG_NUM{sys_wen_i}};
  assign rgn_ren_o = rgn_cs & {`REG_NUM{sys_ren_i}};

  // answer mux, unused regions ack at once with zero data
  always_comb
  begin
    case (rgn)
      `RGN_HK:
      begin
        sys_rdata_o = hk_rdata_i;
        sys_ack_o   = hk_ack_i;
        sys_err_o   = hk_err_i;
      end
      `RGN_DAC:
      begin
        sys_rdata_o = cfg_rdata_i;
        sys_ack_o   = cfg_ack_i;
        sys_err_o   = cfg_err_i;
      end
      default:
      begin
        sys_rdata_o = '0;
        sys_ack_o   = sys_wen_i | sys_ren_i;  // same cycle as strobe
        sys_err_o   = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/hk_regs.sv ====
/* housekeeping registers in bus region 0
   read-only board ID and the digital loopback control bit */
`timescale 1ns/1ps
`default_nettype none

`include "pitaya_params.svh"

module hk_regs
  import pitaya_pkg::*;
(
  input  logic      adc_clk,
  input  logic      rst_i,
  input  bus_word_t sys_addr_i,
  input  bus_word_t sys_wdata_i,
  input  logic      sys_wen_i,
  input  logic      sys_ren_i,
  output bus_word_t sys_rdata_o,
  output logic      sys_ack_o,       // one cycle after strobe
  output logic      sys_err_o,
  output logic      digital_loop_o   // ADC takes DAC samples
);

  logic [`RGN_LSB-1:0] ofs;      // offset inside region
  logic                id_sel;
  logic                loop_sel;
  logic                strobe;
  logic                bad;      // unmapped or ID write
  bus_word_t           rd_word;

  assign ofs      = sys_addr_i[`RGN_LSB-1:0];
  assign id_sel   = (ofs == `HK_ID_OFS);
  assign loop_sel = (ofs == `HK_LOOP_OFS);
  assign strobe   = sys_wen_i | sys_ren_i;
  assign bad      = !(id_sel || loop_sel) || (sys_wen_i && id_sel);

  // zero unless a mapped read
  always_comb
  begin
    rd_word = '0;
    if (sys_ren_i && id_sel)
      rd_word = `PITAYA_ID;
    else if (sys_ren_i && loop_sel)
      rd_word = bus_word_t'(digital_loop_o);  // bit 0 only
  end

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      digital_loop_o <= 1'b0;
      sys_ack_o      <= 1'b0;
      sys_err_o      <= 1'b0;
      sys_rdata_o    <= '0;
    end
    else
    begin
      sys_ack_o   <= strobe;
      sys_err_o   <= strobe & bad;
      sys_rdata_o <= rd_word;
      if (sys_wen_i && loop_sel)
        digital_loop_o <= sys_wdata_i[0];
    end
  end

endmodule

`default_nettype wire

// ==== logic/dac_cfg_regs.sv ====
/* DAC configuration registers in bus region 2
   level and bias per channel, summed by the DAC mixer */
`timescale 1ns/1ps
`default_nettype none

`include "pitaya_params.svh"

module dac_cfg_regs
  import pitaya_pkg::*;
(
  input  logic      adc_clk,
  input  logic      rst_i,
  input  bus_word_t sys_addr_i,
  input  bus_word_t sys_wdata_i,
  input  logic      sys_wen_i,
  input  logic      sys_ren_i,
  output bus_word_t sys_rdata_o,
  output logic      sys_ack_o,
  output logic      sys_err_o,
  output sample_t   lvl_a_o,    // channel A summands
  output sample_t   bias_a_o,
  output sample_t   lvl_b_o,    // channel B summands
  output sample_t   bias_b_o
);

  logic [`RGN_LSB-1:0] ofs;
  logic                hit;      // mapped offset
  sample_t             rd_val;
  sample_t             wr_val;

  assign ofs    = sys_addr_i[`RGN_LSB-1:0];
  assign wr_val = sample_t'(sys_wdata_i[`ADC_W-1:0]);  // low bits of write data

  // read back selection
  always_comb
  begin
    hit = 1'b1;
    case (ofs)
      `CFG_LVL_A_OFS:  rd_val = lvl_a_o;
      `CFG_LVL_B_OFS:  rd_val = lvl_b_o;
      `CFG_BIAS_A_OFS: rd_val = bias_a_o;
      `CFG_BIAS_B_OFS: rd_val = bias_b_o;
      default:
      begin
        rd_val = '0;
        hit    = 1'b0;
      end
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      lvl_a_o     <= '0;
      lvl_b_o     <= '0;
      bias_a_o    <= '0;
      bias_b_o    <= '0;
      sys_ack_o   <= 1'b0;
      sys_err_o   <= 1'b0;
      sys_rdata_o <= '0;
    end
    else
    begin
      sys_ack_o   <= sys_wen_i | sys_ren_i;
      sys_err_o   <= (sys_wen_i | sys_ren_i) & ~hit;
      sys_rdata_o <= sys_ren_i ? {{(`BUS_W-`ADC_W){1'b0}}, rd_val} : '0;  // zero-extend
      if (sys_wen_i)
      begin
        case (ofs)
          `CFG_LVL_A_OFS:  lvl_a_o  <= wr_val;
          `CFG_LVL_B_OFS:  lvl_b_o  <= wr_val;
          `CFG_BIAS_A_OFS: bias_a_o <= wr_val;
          `CFG_BIAS_B_OFS: bias_b_o <= wr_val;
          default:         ;  // err only
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/adc_frontend.sv ====
/* ADC capture and conversion from negative-slope code to two's complement
   digital loopback replaces both channels with the mixer sums */
`timescale 1ns/1ps
`default_nettype none

`include "pitaya_params.svh"

module adc_frontend
  import pitaya_pkg::*;
(
  input  logic     adc_clk,
  input  logic     rst_i,
  input  adc_raw_t adc_dat_a_i,     // raw pins, bits 1:0 unused
  input  adc_raw_t adc_dat_b_i,
  input  logic     digital_loop_i,
  input  sample_t  loop_a_i,        // saturated DAC sums
  input  sample_t  loop_b_i,
  output sample_t  adc_a_o,
  output sample_t  adc_b_o
);

  dac_code_t cap_a;  // input registers
  dac_code_t cap_b;

  // keep top 14 of the 16 pin bits
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      cap_a <= '0;
      cap_b <= '0;
    end
    else
    begin
      cap_a <= adc_dat_a_i[`ADC_RAW_W-1 -: `ADC_W];
      cap_b <= adc_dat_b_i[`ADC_RAW_W-1 -: `ADC_W];
    end
  end

  // msb kept, rest inverted; loopback bypasses the capture
  assign adc_a_o = digital_loop_i ? loop_a_i : sample_t'({cap_a[`ADC_W-1], ~cap_a[`ADC_W-2:0]});
  assign adc_b_o = digital_loop_i ? loop_b_i : sample_t'({cap_b[`ADC_W-1], ~cap_b[`ADC_W-2:0]});

endmodule

`default_nettype wire

// ==== logic/dac_mixer.sv ====
/* per channel sum of level and bias, saturated to 14 bits
   DAC codes registered in negative-slope form, sums fed back for loopback */
`timescale 1ns/1ps
`default_nettype none

`include "pitaya_params.svh"

module dac_mixer
  import pitaya_pkg::*;
(
  input  logic      adc_clk,
  input  logic      rst_i,
  input  sample_t   lvl_a_i,
  input  sample_t   lvl_b_i,
  input  sample_t   bias_a_i,
  input  sample_t   bias_b_i,
  output sample_t   dac_a_o,      // saturated sums, combinational
  output sample_t   dac_b_o,
  output dac_code_t dac_dat_a_o,  // registered DAC codes
  output dac_code_t dac_dat_b_o
);

  // clamp when the guard bit differs from the sign
  function automatic sample_t saturate(input sum_t s);
    if (s[`SUM_W-1] ^ s[`SUM_W-2])
      return {s[`SUM_W-1], {(`ADC_W-1){~s[`SUM_W-1]}}};  // +8191 or -8192
    return s[`ADC_W-1:0];
  endfunction

  sum_t sum_a;
  sum_t sum_b;

  assign sum_a   = sum_t'(lvl_a_i) + sum_t'(bias_a_i);  // sign extended
  assign sum_b   = sum_t'(lvl_b_i) + sum_t'(bias_b_i);
  assign dac_a_o = saturate(sum_a);
  assign dac_b_o = saturate(sum_b);

  //////////////////////////////////////////////////
  // output registers, signed to negative slope

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      dac_dat_a_o <= {1'b0, {(`ADC_W-1){1'b1}}};  // code of zero
      dac_dat_b_o <= {1'b0, {(`ADC_W-1){1'b1}}};
    end
    else
    begin
      dac_dat_a_o <= {dac_a_o[`ADC_W-1], ~dac_a_o[`ADC_W-2:0]};
      dac_dat_b_o <= {dac_b_o[`ADC_W-1], ~dac_b_o[`ADC_W-2:0]};
    end
  end

endmodule

`default_nettype wire

// ==== logic/pitaya_analog_top.sv ====
/* analog data path top level on adc_clk
   bus decoder, register blocks, ADC front end and DAC mixer */
`timescale 1ns/1ps
`default_nettype none

`include "pitaya_params.svh"

module pitaya_analog_top
  import pitaya_pkg::*;
(
  input  logic      adc_clk,
  input  logic      rst_i,
  // system bus
  input  bus_word_t sys_addr_i,
  input  bus_word_t sys_wdata_i,
  input  logic      sys_wen_i,
  input  logic      sys_ren_i,
  output bus_word_t sys_rdata_o,
  output logic      sys_ack_o,
  output logic      sys_err_o,
  // ADC pins and converted streams
  input  adc_raw_t  adc_dat_a_i,
  input  adc_raw_t  adc_dat_b_i,
  output sample_t   adc_a_o,
  output sample_t   adc_b_o,
  // DAC codes
  output dac_code_t dac_dat_a_o,
  output dac_code_t dac_dat_b_o
);

  //////////////////////////////////////////////////
  // local signals

  region_vec_t rgn_wen, rgn_ren;     // one-hot strobes
  bus_word_t   hk_rdata, cfg_rdata;
  logic        hk_ack, hk_err;
  logic        cfg_ack, cfg_err;
  logic        digital_loop;
  sample_t     lvl_a, lvl_b, bias_a, bias_b;
  sample_t     dac_a, dac_b;         // saturated sums

  sys_bus_decoder i_dec (
    .sys_addr_i  (sys_addr_i),  .sys_wen_i   (sys_wen_i),   .sys_ren_i  (sys_ren_i),
    .sys_rdata_o (sys_rdata_o), .sys_ack_o   (sys_ack_o),   .sys_err_o  (sys_err_o),
    .rgn_wen_o   (rgn_wen),     .rgn_ren_o   (rgn_ren),
    .hk_rdata_i  (hk_rdata),    .hk_ack_i    (hk_ack),      .hk_err_i   (hk_err),
    .cfg_rdata_i (cfg_rdata),   .cfg_ack_i   (cfg_ack),     .cfg_err_i  (cfg_err)
  );

  hk_regs i_hk (
    .adc_clk     (adc_clk),     .rst_i       (rst_i),
    .sys_addr_i  (sys_addr_i),  .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (rgn_wen[`RGN_HK]), .sys_ren_i (rgn_ren[`RGN_HK]),  // region 0
    .sys_rdata_o (hk_rdata),    .sys_ack_o   (hk_ack),      .sys_err_o  (hk_err),
    .digital_loop_o (digital_loop)
  );

  dac_cfg_regs i_cfg (
    .adc_clk     (adc_clk),     .rst_i       (rst_i),
    .sys_addr_i  (sys_addr_i),  .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (rgn_wen[`RGN_DAC]), .sys_ren_i (rgn_ren[`RGN_DAC]),  // region 2
    .sys_rdata_o (cfg_rdata),   .sys_ack_o   (cfg_ack),     .sys_err_o  (cfg_err),
    .lvl_a_o     (lvl_a),       .bias_a_o    (bias_a),
    .lvl_b_o     (lvl_b),       .bias_b_o    (bias_b)
  );

  adc_frontend i_adc (
    .adc_clk     (adc_clk),     .rst_i       (rst_i),
    .adc_dat_a_i (adc_dat_a_i), .adc_dat_b_i (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .loop_a_i    (dac_a),       .loop_b_i    (dac_b),       // mixer sums back in
    .adc_a_o     (adc_a_o),     .adc_b_o     (adc_b_o)
  );

  dac_mixer i_dac (
    .adc_clk     (adc_clk),     .rst_i       (rst_i),
    .lvl_a_i     (lvl_a),       .lvl_b_i     (lvl_b),
    .bias_a_i    (bias_a),      .bias_b_i    (bias_b),
    .dac_a_o     (dac_a),       .dac_b_o     (dac_b),
    .dac_dat_a_o (dac_dat_a_o), .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

`default_nettype wire

// ==== tb/tb_pitaya_analog.sv ====
/* testbench for the analog path top level
   reads the test data file, runs one test per data line and reports each */
`timescale 1ns/1ps
`default_nettype none

`include "pitaya_params.svh"

module tb_pitaya_analog
  import pitaya_pkg::*;
();

  localparam int ACK_LIMIT       = 8;   // cycles a bus access may take
  localparam int CYCLES_PER_TEST = 20;  // watchdog budget per data line

  logic      adc_clk;
  logic      rst_i;
  bus_word_t sys_addr_i, sys_wdata_i, sys_rdata_o;
  logic      sys_wen_i, sys_ren_i, sys_ack_o, sys_err_o;
  adc_raw_t  adc_dat_a_i, adc_dat_b_i;
  sample_t   adc_a_o, adc_b_o;
  dac_code_t dac_dat_a_o, dac_dat_b_o;

  string       name_q[$];   // one entry per data line
  string       op_q[$];
  bus_word_t   arg1_q[$], arg2_q[$], arg3_q[$];
  string       cur_name;
  bit          test_bad;    // current test already failed
  bit          loaded;
  bit          file_ok;
  int          n_pass, n_fail;
  logic [31:0] lcg_state;

  pitaya_analog_top dut (
    .adc_clk     (adc_clk),     .rst_i       (rst_i),
    .sys_addr_i  (sys_addr_i),  .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),   .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o), .sys_ack_o   (sys_ack_o),   .sys_err_o (sys_err_o),
    .adc_dat_a_i (adc_dat_a_i), .adc_dat_b_i (adc_dat_b_i),
    .adc_a_o     (adc_a_o),     .adc_b_o     (adc_b_o),
    .dac_dat_a_o (dac_dat_a_o), .dac_dat_b_o (dac_dat_b_o)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;  // 100 MHz
  end

  //////////////////////////////////////////////////
  // helpers

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // sign bit passes and magnitude bits flip
  function automatic sample_t expected_adc(input adc_raw_t raw);
    return sample_t'(raw[`ADC_RAW_W-1 -: `ADC_W] ^ {1'b0, {(`ADC_W-1){1'b1}}});
  endfunction

  // true only for the first fault of a test
  function automatic bit mark_fault();
    mark_fault = !test_bad;
    test_bad   = 1'b1;
  endfunction

  task automatic check_word(input bus_word_t exp, input bus_word_t act);
    if (exp !== act)
    begin
      if (mark_fault())
        $display("ERROR %s: expected %h, actual %h", cur_name, exp, act);
    end
  endtask

  task automatic check_sample(input sample_t exp, input sample_t act);
    if (exp !== act)
    begin
      if (mark_fault())
        $display("ERROR %s: expected %h, actual %h", cur_name, exp, act);
    end
  endtask

  task automatic check_code(input dac_code_t exp, input dac_code_t act);
    if (exp !== act)
    begin
      if (mark_fault())
        $display("ERROR %s: expected %h, actual %h", cur_name, exp, act);
    end
  endtask

  task automatic check_flag(input logic exp, input logic act);
    if (exp !== act)
    begin
      if (mark_fault())
        $display("ERROR %s: expected err %b, actual err %b", cur_name, exp, act);
    end
  endtask

  // one strobe pulse then a wait for ack at the falling edge
  task automatic bus_access(input logic wr, input bus_word_t addr, input bus_word_t wdata,
                            output bus_word_t rdata, output logic err, output logic acked);
    int n;
    acked = 1'b0;
    rdata = '0;
    err   = 1'b0;
    n     = 0;
    @(posedge adc_clk);
    #1;
    sys_addr_i  = addr;   // held until ack
    sys_wdata_i = wdata;
    sys_wen_i   = wr;
    sys_ren_i   = !wr;
    while (!acked && n < ACK_LIMIT)
    begin
      @(negedge adc_clk);
      if (sys_ack_o)
      begin
        acked = 1'b1;
        rdata = sys_rdata_o;
        err   = sys_err_o;
      end
      @(posedge adc_clk);
      #1;
      sys_wen_i = 1'b0;   // single-cycle strobe
      sys_ren_i = 1'b0;
      n++;
    end
  endtask

  task automatic load_tests(output bit ok);
    int        fd;
    int        cnt;
    string     line;
    string     name;
    string     op;
    bus_word_t a1, a2, a3;
    ok = 1'b0;
    fd = $fopen("tb/pitaya_testdata.txt", "r");
    if (fd == 0)
      return;
    while (!$feof(fd))
    begin
      line = "";
      cnt  = $fgets(line, fd);
      if (line.len() > 0 && line.getc(0) != "#")  // skip column notes
      begin
        cnt = $sscanf(line, "%s %s %h %h %h", name, op, a1, a2, a3);
        if (cnt == 5)
        begin
          name_q.push_back(name);
          op_q.push_back(op);
          arg1_q.push_back(a1);
          arg2_q.push_back(a2);
          arg3_q.push_back(a3);
        end
      end
    end
    $fclose(fd);
    ok = (name_q.size() > 0);
  endtask

  //////////////////////////////////////////////////
  // one data line

  task automatic run_test(input int idx);
    string     op;
    bus_word_t a1, a2, a3;
    bus_word_t rdata;
    logic      err;
    logic      acked;
    adc_raw_t  raw_a, raw_b;
    int        i;
    cur_name = name_q[idx];
    op       = op_q[idx];
    a1       = arg1_q[idx];
    a2       = arg2_q[idx];
    a3       = arg3_q[idx];
    test_bad = 1'b0;
    if (op == "write" || op == "read")
    begin
      bus_access(op == "write", a1, a2, rdata, err, acked);
      if (!acked)
      begin
        if (mark_fault())
          $display("%s: no acknowledge from the bus within %0d cycles", cur_name, ACK_LIMIT);
      end
      else
      begin
        if (op == "read")
          check_word(a2, rdata);
        check_flag(a3[0], err);
      end
    end
    else if (op == "adc" || op == "loop")
    begin
      for (i = 0; i < int'(a1); i++)   // a1 = number of random samples
      begin
        lcg_state = lcg_next(lcg_state);
        raw_a     = lcg_state[31:16];
        lcg_state = lcg_next(lcg_state);
        raw_b     = lcg_state[31:16];
        @(posedge adc_clk);
        #1;
        adc_dat_a_i = raw_a;
        adc_dat_b_i = raw_b;
        @(posedge adc_clk);   // capture edge
        @(negedge adc_clk);
        if (op == "adc")
        begin
          check_sample(expected_adc(raw_a), adc_a_o);
          check_sample(expected_adc(raw_b), adc_b_o);
        end
        else
        begin
          check_sample(a2[`ADC_W-1:0], adc_a_o);  // mixer sums with the inputs ignored
          check_sample(a3[`ADC_W-1:0], adc_b_o);
        end
      end
    end
    else if (op == "dac")
    begin
      @(posedge adc_clk);   // codes lag the summands by one cycle
      @(negedge adc_clk);
      check_code(a2[`ADC_W-1:0], dac_dat_a_o);
      check_code(a3[`ADC_W-1:0], dac_dat_b_o);
    end
    else
    begin
      if (mark_fault())
        $display("%s: unknown operation %s in the test data", cur_name, op);
    end
    if (test_bad)
      n_fail++;
    else
    begin
      n_pass++;
      $display("OK    %s", cur_name);
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog

  initial
  begin
    rst_i       = 1'b1;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    lcg_state   = 32'd15;   // seed
    n_pass      = 0;
    n_fail      = 0;
    loaded      = 1'b0;
    load_tests(file_ok);
    if (!file_ok)
    begin
      $display("test data file tb/pitaya_testdata.txt is missing or holds no tests");
      $display("STATUS: FAIL");
    end
    else
    begin
      loaded = 1'b1;
      repeat (4) @(posedge adc_clk);
      #1;
      rst_i = 1'b0;
      foreach (name_q[i])
        run_test(i);
      $display("tests: %0d run, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
      if (n_fail == 0)
        $display("STATUS: PASS");
      else
        $display("STATUS: FAIL");
    end
    $finish;
  end

  initial
  begin
    wait (loaded);
    repeat (name_q.size() * CYCLES_PER_TEST + 8) @(posedge adc_clk);  // 8 for reset
    $display("timeout: tests still running after %0d cycles",
             name_q.size() * CYCLES_PER_TEST + 8);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/pitaya_testdata.txt ====
# name op arg1 arg2 arg3, all args hex
# write: addr wdata exp_err | read: addr exp_rdata exp_err
# adc: samples 0 0 | loop: samples exp_a exp_b | dac: 0 exp_code_a exp_code_b
rst_dac      dac   0        1fff     1fff
rst_loop     read  00000004 00000000 0
adc_conv     adc   8        0        0
id_read      read  00000000 52500a01 0
id_write     write 00000000 12345678 1
id_keep      read  00000000 52500a01 0
hk_unmapped  read  00000010 00000000 1
lvl_a_wr     write 00200000 000003e8 0
bias_a_wr    write 00200008 000007d0 0
lvl_b_wr     write 00200004 fffffe0c 0
bias_b_wr    write 0020000c 00000064 0
lvl_a_rd     read  00200000 000003e8 0
lvl_b_rd     read  00200004 00003e0c 0
bias_b_rd    read  0020000c 00000064 0
cfg_unmapped write 00200010 00000001 1
dac_sum      dac   0        1447     218f
loop_on      write 00000004 00000001 0
loop_rd      read  00000004 00000001 0
loop_sum     loop  6        0bb8     3e70
lvl_a_clip   write 00200000 00001f40 0
bias_a_clip  write 00200008 000003e8 0
lvl_b_clip   write 00200004 000020c0 0
bias_b_clip  write 0020000c 00003c18 0
dac_clip     dac   0        0000     3fff
loop_clip    loop  6        1fff     2000
loop_off     write 00000004 00000000 0
adc_follow   adc   6        0        0
rgn1_read    read  00100000 00000000 0
rgn3_read    read  00300000 00000000 0
rgn5_write   write 00500000 ffffffff 0
rgn7_read    read  00700000 00000000 0

// ==== vlog.f ====
+incdir+logic
logic/pitaya_pkg.sv
logic/sys_bus_decoder.sv
logic/hk_regs.sv
logic/dac_cfg_regs.sv
logic/adc_frontend.sv
logic/dac_mixer.sv
logic/pitaya_analog_top.sv
tb/tb_pitaya_analog.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the analog path testbench with Verilator, run it, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f vlog.f --top-module tb_pitaya_analog -o tb_sim \
  && ./obj_dir/tb_sim | tee sim.log \
  || { echo "build or run failed"; exit 1; }
grep -qx "STATUS: PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
